// ==== list.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_addr_wdata.sv
hw/lsu_rdata_align.sv
hw/lsu_pmp_check.sv
hw/lsu_access_fsm.sv
hw/lsu_top.sv
testbench/lsu_chk.sv
testbench/lsu_tb.sv

// ==== Makefile ====
# Verilator build and run of the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/lsu_tb.sv ====
// load/store unit testbench
// clock, reset and 64-word memory model with random ack delay
// directed tests for stores, loads, misalignment, bus errors and PMP
// check task, watchdog and summary

`timescale 1ns/10ps

`include "lsu_config.svh"

module lsu_tb;

    import lsu_pkg::*;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 5;
    localparam int n_tests      = 5;
    localparam int test_cycles  = 100; // bound per directed test
    localparam int ack_limit    = 20;  // cycles to wait for one ack

    localparam pmp_cfg_t cfg_r   = pmp_cfg_t'(1 << `LSU_PMP_CFG_R);
    localparam pmp_cfg_t cfg_w   = pmp_cfg_t'(1 << `LSU_PMP_CFG_W);
    localparam pmp_cfg_t cfg_l   = pmp_cfg_t'(1 << `LSU_PMP_CFG_L);
    localparam pmp_cfg_t cfg_tor = pmp_cfg_t'(`LSU_PMP_MODE_TOR << `LSU_PMP_CFG_AL);

    logic      clk;
    logic      rstn;
    logic      mo_we;
    word_t     addr;
    word_t     wdata;
    funct3_t   funct3;
    logic      is_store;
    logic      bus_req;
    logic      trap;
    priv_e     priv;
    pmp_addr_t pmp_addr [`LSU_PMP_REGIONS];
    pmp_cfg_t  pmp_cfg  [`LSU_PMP_REGIONS];
    word_t     rdata;
    word_t     mar;
    logic      busy;         // wait_o
    logic      ma_load;
    logic      ma_store;
    logic      be_load;
    logic      be_store;
    word_t     bus_addr;
    word_t     bus_wdata;
    ben_t      bus_ben;
    logic      bus_re;
    logic      bus_we;
    word_t     bus_rdata;
    logic      bus_ack;
    logic      bus_err;

    word_t     mem [64];     // memory model storage
    logic      resp_err;     // next answer is a bus error
    int        errors;
    int        checks;

    lsu_top lsu_top_i (
        .clk_i (clk), .rstn_i (rstn), .mo_we_i (mo_we), .addr_i (addr),
        .wdata_i (wdata), .funct3_i (funct3), .is_store_i (is_store),
        .bus_req_i (bus_req), .trap_i (trap), .priv_i (priv),
        .pmp_addr_i (pmp_addr), .pmp_cfg_i (pmp_cfg), .rdata_o (rdata),
        .mar_o (mar), .wait_o (busy), .ma_load_o (ma_load), .ma_store_o (ma_store),
        .be_load_o (be_load), .be_store_o (be_store), .bus_addr_o (bus_addr),
        .bus_wdata_o (bus_wdata), .bus_ben_o (bus_ben), .bus_re_o (bus_re),
        .bus_we_o (bus_we), .bus_rdata_i (bus_rdata), .bus_ack_i (bus_ack),
        .bus_err_i (bus_err)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ----------------------------------------
    // memory model, ack after 1 to 3 cycles
    initial begin : mem_model
        int unsigned dly;
        logic [5:0]  idx;
        logic        wr;
        logic        fail;
        word_t       wd;
        ben_t        be;
        bus_ack   = 1'b0;
        bus_err   = 1'b0;
        bus_rdata = '0;
        forever begin
            @(negedge clk);
            if (bus_re || bus_we) begin
                idx  = bus_addr[7:2];
                wr   = bus_we;
                wd   = bus_wdata;
                be   = bus_ben;
                fail = resp_err;
                dly  = $urandom_range(3, fail ? 2 : 1); // error needs a pending cycle first
                repeat (dly - 1) @(posedge clk);
                if (fail) begin
                    #1 bus_err = 1'b1; // one cycle ahead of ack
                end
                @(posedge clk);
                #1;
                bus_err = 1'b0;
                bus_ack = 1'b1;
                if (wr && !fail) mem[idx] = merge_bytes(mem[idx], wd, be);
                else if (!wr) bus_rdata = mem[idx]; // held after ack
                @(posedge clk);
                #1 bus_ack = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // expected values from size and offset
    function automatic word_t merge_bytes(input word_t old, input word_t wd, input ben_t be);
        word_t res;
        res = old;
        for (int b = 0; b < `LSU_XLEN / 8; b++) begin
            if (be[b]) res[b*8 +: 8] = wd[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic ben_t expect_ben(input funct3_t f3, input logic [1:0] off);
        case (f3[1:0])
            2'b00:   return 4'b0001 << off;
            2'b01:   return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic word_t expect_wdata(input funct3_t f3, input word_t wd);
        case (f3[1:0])
            2'b00:   return {4{wd[7:0]}};
            2'b01:   return {2{wd[15:0]}};
            default: return wd;
        endcase
    endfunction

    function automatic word_t expect_load(input word_t w, input funct3_t f3, input logic [1:0] off);
        word_t sh;
        sh = w >> {off, 3'b000}; // addressed lane down to bit 0
        case (f3)
            3'b000:  return {{24{sh[7]}}, sh[7:0]};
            3'b100:  return {24'h0, sh[7:0]};
            3'b001:  return {{16{sh[15]}}, sh[15:0]};
            3'b101:  return {16'h0, sh[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic check(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // ----------------------------------------
    // access sequencing
    task automatic start_access(input logic st, input funct3_t f3, input word_t a,
                                input word_t wd, output logic en);
        @(posedge clk);
        #1;
        mo_we    = 1'b1; // latch cycle
        addr     = a;
        wdata    = wd;
        funct3   = f3;
        is_store = st;
        @(posedge clk);
        #1;
        mo_we   = 1'b0;
        bus_req = 1'b1;
        @(negedge clk);
        en = st ? bus_we : bus_re;
        check(word_t'(st ? bus_re : bus_we), 32'd0, "enable of the other direction");
        check(mar, a, "address register");
        check(bus_addr, a, "bus address");
        @(posedge clk);
        #1 bus_req = 1'b0;
    endtask

    task automatic finish_access(output word_t rd, output logic be);
        int n;
        n  = 0;
        rd = '0;
        be = 1'b0;
        @(negedge clk);
        while (!bus_ack && n < ack_limit) begin
            @(negedge clk);
            n++;
        end
        if (!bus_ack) begin
            $display("No bus acknowledge within %0d cycles at %0t ns", ack_limit, $time);
            errors++;
        end else begin
            be = be_load | be_store; // flags seen in the ack cycle
            check(word_t'(busy), 32'd0, "wait in ack cycle");
            @(negedge clk);
            rd = rdata; // registered, one cycle after ack
            check(word_t'(busy), 32'd1, "wait after ack");
        end
    endtask

    task automatic trap_access();
        @(posedge clk);
        #1 trap = 1'b1;
        @(posedge clk);
        #1 trap = 1'b0;
    endtask

    // ----------------------------------------
    // directed tests
    task automatic test_stores();
        funct3_t    f3;
        logic [5:0] idx;
        word_t      old;
        word_t      wd;
        word_t      rd;
        logic       en;
        logic       be;
        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 4; o += 1 << s) begin
                f3  = funct3_t'(s);
                idx = 6'(8 + 4*s + o); // own word per case
                old = $urandom();
                wd  = $urandom();
                mem[idx] = old;
                start_access(1'b1, f3, {24'h0, idx, 2'(o)}, wd, en);
                check(word_t'(en), 32'd1, "store enable");
                check(bus_wdata, expect_wdata(f3, wd), "store data replication");
                check(word_t'(bus_ben), word_t'(expect_ben(f3, 2'(o))), "store byte enables");
                finish_access(rd, be);
                check(mem[idx], merge_bytes(old, expect_wdata(f3, wd), expect_ben(f3, 2'(o))),
                      "merged memory word");
            end
        end
    endtask

    task automatic test_loads();
        funct3_t    f3;
        logic [5:0] idx;
        word_t      w;
        word_t      rd;
        logic       en;
        logic       be;
        for (int u = 0; u < 2; u++) begin
            for (int s = 0; s < 3 - u; s++) begin // no unsigned word load on rv32
                f3  = funct3_t'(4*u + s);
                idx = 6'(20 + 3*u + s);
                w   = $urandom();
                mem[idx] = w;
                for (int o = 0; o < 4; o += 1 << s) begin
                    start_access(1'b0, f3, {24'h0, idx, 2'(o)}, '0, en);
                    check(word_t'(en), 32'd1, "load enable");
                    finish_access(rd, be);
                    check(rd, expect_load(w, f3, 2'(o)), "load data");
                end
            end
        end
    endtask

    task automatic misaligned_case(input logic st, input funct3_t f3, input logic [1:0] off);
        logic [5:0] idx;
        word_t      old;
        logic       en;
        idx = 6'd30 + 6'(off);
        old = mem[idx];
        start_access(st, f3, {24'h0, idx, off}, $urandom(), en);
        check(word_t'(en), 32'd0, "misaligned access enable");
        @(negedge clk);
        check(word_t'(ma_load), word_t'(!st), "misaligned load flag");
        check(word_t'(ma_store), word_t'(st), "misaligned store flag");
        trap_access();
        @(negedge clk);
        check(word_t'(ma_load | ma_store), 32'd0, "misaligned flags after trap");
        if (st) begin
            check(mem[idx], old, "memory after misaligned store");
        end
    endtask

    task automatic test_misaligned();
        misaligned_case(1'b0, 3'b001, 2'd1);
        misaligned_case(1'b1, 3'b001, 2'd3);
        misaligned_case(1'b0, 3'b010, 2'd2);
        misaligned_case(1'b1, 3'b010, 2'd1);
        misaligned_case(1'b0, 3'b010, 2'd3);
    endtask

    task automatic test_bus_errors();
        logic [5:0] idx;
        word_t      old;
        word_t      rd;
        logic       en;
        logic       be;
        for (int st = 0; st < 2; st++) begin
            idx = 6'(40 + st);
            old = mem[idx];
            resp_err = 1'b1;
            start_access(1'(st), 3'b010, {24'h0, idx, 2'b00}, $urandom(), en);
            check(word_t'(en), 32'd1, "enable before bus error");
            finish_access(rd, be);
            resp_err = 1'b0;
            check(word_t'(be), 32'd1, "bus error flag in ack cycle");
            check(word_t'(be_load | be_store), 32'd0, "error flags after access end");
            if (st == 1) begin
                check(mem[idx], old, "memory after failed store");
            end
        end
    endtask

    task automatic pmp_case(input priv_e p, input logic st, input word_t a, input logic blocked);
        word_t rd;
        logic  en;
        logic  be;
        @(posedge clk);
        #1 priv = p;
        start_access(st, 3'b010, a, $urandom(), en);
        check(word_t'(en), word_t'(!blocked), "PMP enable");
        if (blocked) begin
            @(negedge clk);
            @(negedge clk); // fault recorded after first pending cycle
            check(word_t'(st ? be_store : be_load), 32'd1, "PMP fault flag");
            trap_access();
        end else begin
            finish_access(rd, be);
            check(word_t'(be), 32'd0, "error flag on permitted access");
        end
    endtask

    task automatic test_pmp();
        @(posedge clk);
        #1;
        pmp_addr[0] = 32'h40; // [0x00, 0x40) read only
        pmp_cfg[0]  = cfg_tor | cfg_r;
        pmp_addr[1] = 32'h80; // [0x40, 0x80) write only
        pmp_cfg[1]  = cfg_tor | cfg_w;
        pmp_addr[2] = 32'hc0; // [0x80, 0xc0) locked, read only
        pmp_cfg[2]  = cfg_tor | cfg_r | cfg_l;
        pmp_addr[3] = 32'he0; // [0xc0, 0xe0) read and write
        pmp_cfg[3]  = cfg_tor | cfg_r | cfg_w;
        pmp_case(PRIV_U, 1'b0, 32'h10, 1'b0);
        pmp_case(PRIV_U, 1'b1, 32'h14, 1'b1); // no W
        pmp_case(PRIV_U, 1'b0, 32'h50, 1'b1); // no R
        pmp_case(PRIV_U, 1'b1, 32'h54, 1'b0);
        pmp_case(PRIV_M, 1'b1, 32'h18, 1'b0); // unlocked, M passes
        pmp_case(PRIV_M, 1'b0, 32'h58, 1'b0);
        pmp_case(PRIV_M, 1'b1, 32'h90, 1'b1); // locked without W
        pmp_case(PRIV_M, 1'b0, 32'h94, 1'b0);
        pmp_case(PRIV_U, 1'b1, 32'hc4, 1'b0);
        pmp_case(PRIV_U, 1'b0, 32'hf0, 1'b1); // above all regions
        pmp_case(PRIV_M, 1'b0, 32'hf4, 1'b0);
        @(posedge clk);
        #1;
        priv = PRIV_M;
        for (int r = 0; r < `LSU_PMP_REGIONS; r++) begin
            pmp_cfg[r] = '0;
        end
    endtask

    // ----------------------------------------
    initial begin : watchdog
        #((n_tests * test_cycles + reset_cycles) * clk_period);
        $display("Watchdog expired, the tests did not complete in time");
        $display("Finished with errors");
        $finish;
    end

    initial begin : main
        void'($urandom(32'ha5b9_f18c));
        errors   = 0;
        checks   = 0;
        rstn     = 1'b0;
        mo_we    = 1'b0;
        addr     = '0;
        wdata    = '0;
        funct3   = '0;
        is_store = 1'b0;
        bus_req  = 1'b0;
        trap     = 1'b0;
        priv     = PRIV_M;
        resp_err = 1'b0;
        for (int r = 0; r < `LSU_PMP_REGIONS; r++) begin
            pmp_addr[r] = '0;
            pmp_cfg[r]  = '0; // mode off
        end
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'h9e37_79b9 * word_t'(i + 1); // differs per word
        end
        repeat (reset_cycles) @(posedge clk);
        #1 rstn = 1'b1;
        test_stores();
        test_loads();
        test_misaligned();
        test_bus_errors();
        test_pmp();
        errors += lsu_top_i.lsu_access_fsm_i.chk_i.fail_cnt;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== testbench/lsu_chk.sv ====
// access FSM checker, bound into lsu_access_fsm
// enable exclusivity, blocked and stray enables, idle flags

`timescale 1ns/10ps

module lsu_chk (
    input logic                clk_i,
    input logic                rstn_i,
    input logic                bus_req_i,
    input logic                misaligned_i,
    input logic                bus_re_i,
    input logic                bus_we_i,
    input logic                ma_load_i,
    input logic                ma_store_i,
    input logic                be_load_i,
    input logic                be_store_i,
    input lsu_pkg::lsu_state_e state_i
);

    import lsu_pkg::*;

    int unsigned fail_cnt = 0; // failed assertions so far
    logic        any_en;
    logic        any_flag;

    assign any_en   = bus_re_i | bus_we_i;
    assign any_flag = ma_load_i | ma_store_i | be_load_i | be_store_i;

    // ----------------------------------------
    a_one_en: assert property (@(posedge clk_i) disable iff (!rstn_i) !(bus_re_i && bus_we_i))
    else begin
        $error("read and write enable high together");
        fail_cnt++;
    end

    a_no_misal_en: assert property (@(posedge clk_i) disable iff (!rstn_i)
        any_en |-> !misaligned_i)
    else begin
        $error("enable issued for a misaligned access");
        fail_cnt++;
    end

    a_en_in_req: assert property (@(posedge clk_i) disable iff (!rstn_i) any_en |-> bus_req_i)
    else begin
        $error("enable outside the request cycle");
        fail_cnt++;
    end

    a_idle_flags: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_i == ST_IDLE) |-> !any_flag)
    else begin
        $error("error flag high while idle");
        fail_cnt++;
    end

endmodule

bind lsu_access_fsm lsu_chk chk_i (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .bus_req_i    (bus_req_i),
    .misaligned_i (misaligned_i),
    .bus_re_i     (bus_re_o),
    .bus_we_i     (bus_we_o),
    .ma_load_i    (ma_load_o),
    .ma_store_i   (ma_store_o),
    .be_load_i    (be_load_o),
    .be_store_i   (be_store_o),
    .state_i      (state)
);

// ==== hw/lsu_top.sv ====
// load/store unit top level
// address/write path, read path, PMP checker and access FSM

`timescale 1ns/10ps

`include "lsu_config.svh"

module lsu_top (
    input  logic               clk_i,                         // rising edge
    input  logic               rstn_i,                        // async, active low
    // core side
    input  logic               mo_we_i,                       // latch address and data
    input  lsu_pkg::word_t     addr_i,                        // access address
    input  lsu_pkg::word_t     wdata_i,                       // store data
    input  lsu_pkg::funct3_t   funct3_i,                      // size and signedness
    input  logic               is_store_i,                    // store when high
    input  logic               bus_req_i,                     // start access
    input  logic               trap_i,                        // abandon access
    input  lsu_pkg::priv_e     priv_i,                        // effective privilege
    input  lsu_pkg::pmp_addr_t pmp_addr_i [`LSU_PMP_REGIONS], // region bounds
    input  lsu_pkg::pmp_cfg_t  pmp_cfg_i  [`LSU_PMP_REGIONS], // region configs
    output lsu_pkg::word_t     rdata_o,                       // load result
    output lsu_pkg::word_t     mar_o,                         // address for trap value
    output logic               wait_o,                        // access not done
    output logic               ma_load_o,
    output logic               ma_store_o,
    output logic               be_load_o,
    output logic               be_store_o,
    // data bus
    output lsu_pkg::word_t     bus_addr_o,
    output lsu_pkg::word_t     bus_wdata_o,
    output lsu_pkg::ben_t      bus_ben_o,
    output logic               bus_re_o,
    output logic               bus_we_o,
    input  lsu_pkg::word_t     bus_rdata_i,
    input  logic               bus_ack_i,
    input  logic               bus_err_i
);

    import lsu_pkg::*;

    word_t mar;        // shared address register
    logic  misaligned;
    logic  ld_fault;   // comb PMP results
    logic  st_fault;

    assign mar_o      = mar;
    assign bus_addr_o = mar;
    assign wait_o     = ~bus_ack_i; // low only in ack cycle

    // ----------------------------------------
    lsu_addr_wdata lsu_addr_wdata_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .mo_we_i      (mo_we_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .funct3_i     (funct3_i),
        .mar_o        (mar),
        .misaligned_o (misaligned),
        .bus_wdata_o  (bus_wdata_o),
        .bus_ben_o    (bus_ben_o)
    );

    lsu_rdata_align lsu_rdata_align_i (
        .clk_i       (clk_i),
        .funct3_i    (funct3_i),
        .mar_i       (mar),
        .bus_rdata_i (bus_rdata_i),
        .rdata_o     (rdata_o)
    );

    lsu_pmp_check lsu_pmp_check_i (
        .addr_i     (addr_i),     // unlatched, stable during access
        .priv_i     (priv_i),
        .pmp_addr_i (pmp_addr_i),
        .pmp_cfg_i  (pmp_cfg_i),
        .ld_fault_o (ld_fault),
        .st_fault_o (st_fault)
    );

    lsu_access_fsm lsu_access_fsm_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .bus_req_i    (bus_req_i),
        .is_store_i   (is_store_i),
        .trap_i       (trap_i),
        .misaligned_i (misaligned),
        .ld_fault_i   (ld_fault),
        .st_fault_i   (st_fault),
        .bus_ack_i    (bus_ack_i),
        .bus_err_i    (bus_err_i),
        .bus_re_o     (bus_re_o),
        .bus_we_o     (bus_we_o),
        .ma_load_o    (ma_load_o),
        .ma_store_o   (ma_store_o),
        .be_load_o    (be_load_o),
        .be_store_o   (be_store_o)
    );

endmodule

// ==== hw/lsu_access_fsm.sv ====
// pending-access arbiter FSM
// error accumulation, bus enables and error flags

`timescale 1ns/10ps

module lsu_access_fsm (
    input  logic clk_i,        // rising edge
    input  logic rstn_i,       // async, active low
    input  logic bus_req_i,    // access start strobe
    input  logic is_store_i,   // store when high
    input  logic trap_i,       // abandon pending access
    input  logic misaligned_i, // from address register
    input  logic ld_fault_i,   // comb PMP load fault
    input  logic st_fault_i,   // comb PMP store fault
    input  logic bus_ack_i,    // slave done
    input  logic bus_err_i,    // slave error, with ack
    output logic bus_re_o,     // read enable, one cycle
    output logic bus_we_o,     // write enable, one cycle
    output logic ma_load_o,    // misaligned load
    output logic ma_store_o,   // misaligned store
    output logic be_load_o,    // load bus or PMP error
    output logic be_store_o    // store bus or PMP error
);

    import lsu_pkg::*;

    lsu_state_e state;
    logic       err;       // error seen on this access
    logic       pmp_r_err; // registered load fault
    logic       pmp_w_err; // registered store fault
    logic       pend;

    assign pend = (state == ST_PEND);

    // ----------------------------------------
    // arbiter
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state     <= ST_IDLE;
            err       <= 1'b0;
            pmp_r_err <= 1'b0;
            pmp_w_err <= 1'b0;
        end else begin
            pmp_r_err <= ld_fault_i; // sampled every cycle
            pmp_w_err <= st_fault_i;
            unique case (state)
                ST_IDLE: begin
                    err <= 1'b0; // fresh access
                    if (bus_req_i) state <= ST_PEND;
                end
                ST_PEND: begin
                    if (bus_err_i || (is_store_i && pmp_w_err) || (!is_store_i && pmp_r_err))
                        err <= 1'b1; // sticky until idle
                    if (bus_ack_i || trap_i) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // enables, blocked on misalign or fault
    assign bus_re_o = bus_req_i & ~is_store_i & ~misaligned_i & ~pmp_r_err;
    assign bus_we_o = bus_req_i &  is_store_i & ~misaligned_i & ~pmp_w_err;

    // flags only while pending
    assign ma_load_o  = pend & ~is_store_i & misaligned_i;
    assign ma_store_o = pend &  is_store_i & misaligned_i;
    assign be_load_o  = pend & ~is_store_i & err;
    assign be_store_o = pend &  is_store_i & err;

endmodule

// ==== hw/lsu_pmp_check.sv ====
// data-access PMP checker, TOR regions only
// region match, M/U permission and static priority chain

`timescale 1ns/10ps

`include "lsu_config.svh"

module lsu_pmp_check (
    input  lsu_pkg::word_t     addr_i,                        // data access address
    input  lsu_pkg::priv_e     priv_i,                        // effective privilege
    input  lsu_pkg::pmp_addr_t pmp_addr_i [`LSU_PMP_REGIONS], // region upper bounds
    input  lsu_pkg::pmp_cfg_t  pmp_cfg_i  [`LSU_PMP_REGIONS], // region config bytes
    output logic              ld_fault_o,                    // load not permitted
    output logic              st_fault_o                     // store not permitted
);

    import lsu_pkg::*;

    localparam int NR  = `LSU_PMP_REGIONS;
    localparam int LSB = `LSU_PMP_GRAN_LSB;

    logic [NR-1:0] cmp_ge;  // at or above lower bound
    logic [NR-1:0] cmp_lt;  // below upper bound
    logic [NR-1:0] match;   // region hit in TOR mode
    logic [NR-1:0] perm_rd; // read allowed
    logic [NR-1:0] perm_wr; // write allowed

    // ----------------------------------------
    // per-region match and permission
    for (genvar r = 0; r < NR; r++) begin : g_region
        logic is_tor;
        logic locked;

        if (r == 0) begin : g_first
            assign cmp_ge[r] = 1'b1; // base is zero
        end else begin : g_rest
            assign cmp_ge[r] = addr_i[`LSU_XLEN-1:LSB] >= pmp_addr_i[r-1][`LSU_XLEN-1:LSB];
        end
        assign cmp_lt[r] = addr_i[`LSU_XLEN-1:LSB] < pmp_addr_i[r][`LSU_XLEN-1:LSB];

        assign is_tor   = pmp_cfg_i[r][`LSU_PMP_CFG_AH:`LSU_PMP_CFG_AL] == 2'(`LSU_PMP_MODE_TOR);
        assign match[r] = is_tor & cmp_ge[r] & cmp_lt[r];

        // M mode sees R/W only on locked entries
        assign locked     = pmp_cfg_i[r][`LSU_PMP_CFG_L];
        assign perm_rd[r] = (priv_i == PRIV_M) ? (~locked | pmp_cfg_i[r][`LSU_PMP_CFG_R])
                                               : pmp_cfg_i[r][`LSU_PMP_CFG_R];
        assign perm_wr[r] = (priv_i == PRIV_M) ? (~locked | pmp_cfg_i[r][`LSU_PMP_CFG_W])
                                               : pmp_cfg_i[r][`LSU_PMP_CFG_W];
    end

    // ----------------------------------------
    // priority mux chain, lowest region wins
    always_comb begin
        logic [NR:0] ld_chain;
        logic [NR:0] st_chain;

        ld_chain[NR] = (priv_i != PRIV_M); // no match, U faults
        st_chain[NR] = (priv_i != PRIV_M);
        for (int r = NR-1; r >= 0; r--) begin
            ld_chain[r] = match[r] ? ~perm_rd[r] : ld_chain[r+1];
            st_chain[r] = match[r] ? ~perm_wr[r] : st_chain[r+1];
        end
        ld_fault_o = ld_chain[0];
        st_fault_o = st_chain[0];
    end

endmodule

// ==== hw/lsu_rdata_align.sv ====
// read-data lane selection
// sign or zero extension, registered output

`timescale 1ns/10ps

`include "lsu_config.svh"

module lsu_rdata_align (
    input  logic            clk_i,       // rising edge
    input  lsu_pkg::funct3_t funct3_i,    // size and signedness
    input  lsu_pkg::word_t   mar_i,       // latched address, low bits pick lane
    input  lsu_pkg::word_t   bus_rdata_i, // raw bus word
    output lsu_pkg::word_t   rdata_o      // aligned load result
);

    import lsu_pkg::*;

    logic [7:0]  byte_sel; // addressed byte
    logic [15:0] half_sel; // addressed half-word
    logic        sign_en;  // signed load
    word_t       rdata_nxt;

    assign sign_en  = ~funct3_i[2];                                // lbu, lhu clear it
    assign byte_sel = bus_rdata_i[{mar_i[1:0], 3'b000} +: 8];       // lane by mar[1:0]
    assign half_sel = bus_rdata_i[{mar_i[1], 4'b0000} +: 16];       // half by mar[1]

    // ----------------------------------------
    // extension
    always_comb begin
        unique case (funct3_i[1:0])
            2'b00: begin
                rdata_nxt = {{(`LSU_XLEN-8){sign_en & byte_sel[7]}}, byte_sel};
            end
            2'b01: begin
                rdata_nxt = {{(`LSU_XLEN-16){sign_en & half_sel[15]}}, half_sel};
            end
            default: rdata_nxt = bus_rdata_i; // full word
        endcase
    end

    // sampled every cycle, valid after ack
    always_ff @(posedge clk_i) begin
        rdata_o <= rdata_nxt;
    end

endmodule

// ==== hw/lsu_addr_wdata.sv ====
// memory address register and misalignment detection
// write-data replication and byte enables

`timescale 1ns/10ps

`include "lsu_config.svh"

module lsu_addr_wdata (
    input  logic            clk_i,        // rising edge
    input  logic            rstn_i,       // async, active low
    input  logic            mo_we_i,      // latch strobe from core
    input  lsu_pkg::word_t   addr_i,       // access address
    input  lsu_pkg::word_t   wdata_i,      // store data, low aligned
    input  lsu_pkg::funct3_t funct3_i,     // access size
    output lsu_pkg::word_t   mar_o,        // memory address register
    output logic            misaligned_o, // registered alignment fault
    output lsu_pkg::word_t   bus_wdata_o,  // replicated store data
    output lsu_pkg::ben_t    bus_ben_o     // byte lane enables
);

    import lsu_pkg::*;

    ben_t ben_nxt; // enables for the incoming access

    // ----------------------------------------
    // address and alignment
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mar_o        <= '0;
            misaligned_o <= 1'b0;
        end else if (mo_we_i) begin
            mar_o <= addr_i;
            unique case (funct3_i[1:0])
                2'b01:   misaligned_o <= addr_i[0];             // half-word
                2'b10:   misaligned_o <= addr_i[1] | addr_i[0]; // word
                default: misaligned_o <= 1'b0;                  // byte, no rv64 size
            endcase
        end
    end

    // lane enables from size and low address bits
    always_comb begin
        unique case (funct3_i[1:0])
            2'b00:   ben_nxt = ben_t'(1) << addr_i[1:0];              // one lane
            2'b01:   ben_nxt = ben_t'(2'b11) << {addr_i[1], 1'b0};    // lower or upper half
            default: ben_nxt = '1;                                    // full word
        endcase
    end

    // ----------------------------------------
    // write data, no reset on payload
    always_ff @(posedge clk_i) begin
        if (mo_we_i) begin
            bus_ben_o <= ben_nxt;
            unique case (funct3_i[1:0])
                2'b00: begin
                    for (int i = 0; i < `LSU_XLEN/8; i++) begin
                        bus_wdata_o[i*8 +: 8] <= wdata_i[7:0]; // byte in every lane
                    end
                end
                2'b01: begin
                    for (int i = 0; i < `LSU_XLEN/16; i++) begin
                        bus_wdata_o[i*16 +: 16] <= wdata_i[15:0]; // both halves
                    end
                end
                default: bus_wdata_o <= wdata_i; // word as is
            endcase
        end
    end

endmodule

// ==== hw/lsu_pkg.sv ====
// load/store unit package
// word, byte-enable, funct3 and PMP typedefs
// privilege and arbiter state enums

`include "lsu_config.svh"

package lsu_pkg;

    // ----------------------------------------
    // data path types
    typedef logic [`LSU_XLEN-1:0]   word_t;   // data word or address
    typedef logic [`LSU_XLEN/8-1:0] ben_t;    // one enable per byte lane
    typedef logic [2:0]             funct3_t; // size in [1:0], unsigned in [2]

    // ----------------------------------------
    // PMP types
    typedef logic [`LSU_XLEN-1:0] pmp_addr_t; // upper bound of a TOR region
    typedef logic [7:0]           pmp_cfg_t;  // L..AH AL W R configuration byte

    typedef enum logic {
        PRIV_U = 1'b0, // user mode
        PRIV_M = 1'b1  // machine mode
    } priv_e;

    // ----------------------------------------
    // access arbiter state
    typedef enum logic {
        ST_IDLE = 1'b0, // no access in flight
        ST_PEND = 1'b1  // waiting for ack or trap
    } lsu_state_e;

endpackage

// ==== hw/lsu_config.svh ====
// load/store unit configuration macros
// data width, PMP region count and granularity
// PMP configuration byte bit positions and TOR mode code

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// ----------------------------------------
`define LSU_XLEN          32 // data path width
`define LSU_PMP_REGIONS   4  // number of PMP regions
`define LSU_PMP_GRAN_LSB  2  // lowest compared address bit, 4 byte granularity

// ----------------------------------------
`define LSU_PMP_CFG_R     0  // read permit
`define LSU_PMP_CFG_W     1  // write permit
`define LSU_PMP_CFG_AL    3  // mode field low bit
`define LSU_PMP_CFG_AH    4  // mode field high bit
`define LSU_PMP_CFG_L     7  // locked entry
`define LSU_PMP_MODE_TOR  1  // top of range mode

`endif
